/* all.f */
hw/kmac_cmd_pkg.sv
hw/sha3_cfg_pkg.sv
hw/kmac_cmd_if.sv
hw/kmac_errchk.sv
hw/kmac_round_ctrl.sv
hw/kmac_err_log.sv
hw/kmac_ctrl_top.sv
tests/kmac_clk_gen.sv
tests/kmac_asserts.sv
tests/kmac_tb.sv

/* hw/kmac_cmd_if.sv */
// Filtered command and core status between checker and round controller; all signals are strobes
`timescale 1ns/1ps

interface kmac_cmd_if;

  // Registered command, CmdNone when nothing is forwarded
  kmac_cmd_pkg::kmac_cmd_e cmd;
  // Clear-after-error accepted by the checker
  logic clear;
  // Core status pulses
  logic absorbed;
  logic done;

  // Sequence checker side
  modport chk (output cmd, output clear, input absorbed, input done);

  // Round controller side
  modport core (input cmd, input clear, output absorbed, output done);

endinterface

/* hw/kmac_cmd_pkg.sv */
// Command, error and sequence-state encodings; widths are fixed and mirrored in the error info layout
package kmac_cmd_pkg;

  // Field widths used by the error record and info layout
  localparam int CmdWidth     = 6;
  localparam int ErrCodeWidth = 8;
  localparam int StWidth      = 3;
  localparam int ErrInfoWidth = 24;

  // Software commands, sparse values so a stuck bit never forms another command
  typedef enum logic [CmdWidth-1:0] {
    CmdNone      = 6'b001011,
    CmdStart     = 6'b011101,
    CmdProcess   = 6'b101110,
    CmdManualRun = 6'b110001,
    CmdDone      = 6'b010110
  } kmac_cmd_e;

  // Values match the ERR_CODE register layout
  typedef enum logic [ErrCodeWidth-1:0] {
    ErrNone                         = 8'h00,
    ErrUnexpectedModeStrength       = 8'h06,
    ErrIncorrectFunctionName        = 8'h07,
    ErrSwCmdSequence                = 8'h08,
    ErrSwHashingWithoutEntropyReady = 8'h09
  } err_code_e;

  typedef struct packed {
    logic                    valid;
    err_code_e               code;
    logic [ErrInfoWidth-1:0] info;
  } err_t;

  // Logical sequence state, also reported in the info field
  typedef enum logic [StWidth-1:0] {
    StIdle,
    StMsgFeed,
    StProcessing,
    StAbsorbed,
    StSqueezing,
    StTerminalError
  } seq_st_e;

  // encode_string("KMAC") as held in the first six PREFIX bytes
  localparam logic [47:0] EncodedStringKMAC = 48'h4341_4D4B_2001;

endpackage

/* hw/kmac_ctrl_top.sv */
// Command sequencing top; status inputs are plain levels and commands one-cycle strobes
`timescale 1ns/1ps

module kmac_ctrl_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  sha3_cfg_pkg::sha3_mode_e              cfg_mode_i,
  input  sha3_cfg_pkg::keccak_strength_e        cfg_strength_i,
  input  logic                                  kmac_en_i,
  input  logic [47:0]                           cfg_prefix_i,
  input  logic                                  cfg_en_unsupported_i,
  input  logic                                  entropy_ready_i,
  input  logic                                  app_active_i,
  input  logic                                  esc_i,
  input  logic                                  err_processed_i,
  input  logic                                  clear_after_error_i,
  input  kmac_cmd_pkg::kmac_cmd_e               sw_cmd_i,
  output logic                                  absorbed_o,
  output logic                                  done_o,
  output logic                                  busy_o,
  output logic                                  err_valid_o,
  output kmac_cmd_pkg::err_code_e               err_code_o,
  output logic [kmac_cmd_pkg::ErrInfoWidth-1:0] err_info_o,
  output logic                                  fsm_error_o
);

  kmac_cmd_pkg::err_t error;

  kmac_cmd_if u_cmd_if ();

  // Sequence checker and command filter
  kmac_errchk u_errchk (
    .clk_i, .rst_ni, .cfg_mode_i, .cfg_strength_i, .kmac_en_i, .cfg_prefix_i,
    .cfg_en_unsupported_i, .entropy_ready_i, .app_active_i, .esc_i,
    .err_processed_i, .clear_after_error_i, .sw_cmd_i,
    .error_o     (error),
    .fsm_error_o (fsm_error_o),
    .core_if     (u_cmd_if.chk)
  );

  kmac_round_ctrl u_round_ctrl (
    .clk_i, .rst_ni,
    .busy_o  (busy_o),
    .core_if (u_cmd_if.core)
  );

  kmac_err_log u_err_log (
    .clk_i, .rst_ni, .err_processed_i, .err_valid_o, .err_code_o, .err_info_o,
    .error_i (error)
  );

  // Core status pulses go straight out
  assign absorbed_o = u_cmd_if.absorbed;
  assign done_o     = u_cmd_if.done;

endmodule

/* hw/kmac_err_log.sv */
// Error code register holding the first error; codes and info read as zero while nothing is logged
`timescale 1ns/1ps

module kmac_err_log (
  input  logic                                    clk_i,
  input  logic                                    rst_ni,
  input  kmac_cmd_pkg::err_t                      error_i,
  input  logic                                    err_processed_i,
  output logic                                    err_valid_o,
  output kmac_cmd_pkg::err_code_e                 err_code_o,
  output logic [kmac_cmd_pkg::ErrInfoWidth-1:0]   err_info_o
);

  logic capture;

  // Empty log, or one being acknowledged this cycle, takes a new error
  assign capture = error_i.valid && (!err_valid_o || err_processed_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_o <= 1'b0;
      err_code_o  <= kmac_cmd_pkg::ErrNone;
      err_info_o  <= '0;
    end else if (capture) begin
      err_valid_o <= 1'b1;
      err_code_o  <= error_i.code;
      err_info_o  <= error_i.info;
    end else if (err_processed_i) begin
      // Acknowledge with nothing new pending
      err_valid_o <= 1'b0;
      err_code_o  <= kmac_cmd_pkg::ErrNone;
      err_info_o  <= '0;
    end
  end

endmodule

/* hw/kmac_errchk.sv */
// Checks command order and start-time configuration; blocked commands are dropped, never queued
`timescale 1ns/1ps

module kmac_errchk (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  sha3_cfg_pkg::sha3_mode_e       cfg_mode_i,
  input  sha3_cfg_pkg::keccak_strength_e cfg_strength_i,
  input  logic                           kmac_en_i,
  input  logic [47:0]                    cfg_prefix_i,
  input  logic                           cfg_en_unsupported_i,
  input  logic                           entropy_ready_i,
  input  logic                           app_active_i,
  input  logic                           esc_i,
  input  logic                           err_processed_i,
  input  logic                           clear_after_error_i,
  input  kmac_cmd_pkg::kmac_cmd_e        sw_cmd_i,
  output kmac_cmd_pkg::err_t             error_o,
  output logic                           fsm_error_o,
  kmac_cmd_if.chk                        core_if
);

  kmac_cmd_pkg::seq_st_e st_q, st_d;

  logic       start_ok;
  logic       err_swsequence;
  logic       err_modestrength;
  logic       err_prefix;
  logic       err_entropy;
  logic       cfg_entropy_ready_q;
  logic       block_swcmd;
  logic       clear_ok;
  logic [3:0] err_flags;

  ////////////////////////////////////////////////////////////
  // Sequence checks
  ////////////////////////////////////////////////////////////

  // Any state outside the five working ones counts as terminal
  assign fsm_error_o = !(st_q inside {kmac_cmd_pkg::StIdle, kmac_cmd_pkg::StMsgFeed,
                                      kmac_cmd_pkg::StProcessing, kmac_cmd_pkg::StAbsorbed,
                                      kmac_cmd_pkg::StSqueezing});

  // Hash begins here, so configuration is only checked on this move
  assign start_ok = (st_q == kmac_cmd_pkg::StIdle) && !app_active_i &&
                    (sw_cmd_i == kmac_cmd_pkg::CmdStart);

  always_comb begin
    err_swsequence = 1'b0;
    case (st_q)
      // Only Start leaves Idle
      kmac_cmd_pkg::StIdle: begin
        err_swsequence = !(sw_cmd_i inside {kmac_cmd_pkg::CmdNone, kmac_cmd_pkg::CmdStart});
      end
      kmac_cmd_pkg::StMsgFeed: begin
        err_swsequence = !(sw_cmd_i inside {kmac_cmd_pkg::CmdNone, kmac_cmd_pkg::CmdProcess});
      end
      // Permutation running, software must stay quiet
      kmac_cmd_pkg::StProcessing, kmac_cmd_pkg::StSqueezing: begin
        err_swsequence = (sw_cmd_i != kmac_cmd_pkg::CmdNone);
      end
      kmac_cmd_pkg::StAbsorbed: begin
        err_swsequence = !(sw_cmd_i inside {kmac_cmd_pkg::CmdNone, kmac_cmd_pkg::CmdManualRun,
                                            kmac_cmd_pkg::CmdDone});
      end
      default: begin
        err_swsequence = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Configuration checks at Start
  ////////////////////////////////////////////////////////////

  // SHA3 takes the fixed digest sizes, SHAKE/cSHAKE only 128 and 256
  assign err_modestrength = start_ok &&
    !(((cfg_mode_i == sha3_cfg_pkg::Sha3) &&
       (cfg_strength_i inside {sha3_cfg_pkg::L224, sha3_cfg_pkg::L256,
                               sha3_cfg_pkg::L384, sha3_cfg_pkg::L512})) ||
      ((cfg_mode_i inside {sha3_cfg_pkg::Shake, sha3_cfg_pkg::CShake}) &&
       (cfg_strength_i inside {sha3_cfg_pkg::L128, sha3_cfg_pkg::L256})));

  // Reported only, the hash still runs
  assign err_prefix = start_ok && kmac_en_i && (cfg_prefix_i != kmac_cmd_pkg::EncodedStringKMAC);

  // Entropy ready arrives as a pulse, so keep it until acknowledged
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_entropy_ready_q <= 1'b0;
    end else if (err_processed_i) begin
      cfg_entropy_ready_q <= 1'b0;
    end else if (entropy_ready_i && (st_q == kmac_cmd_pkg::StIdle)) begin
      cfg_entropy_ready_q <= 1'b1;
    end
  end

  assign err_entropy = start_ok && kmac_en_i && !cfg_entropy_ready_q;

  // Mode error blocks only when unsupported configs are not allowed
  assign block_swcmd = err_swsequence || err_entropy || fsm_error_o ||
                       (err_modestrength && !cfg_en_unsupported_i);

  ////////////////////////////////////////////////////////////
  // Command filter and state register
  ////////////////////////////////////////////////////////////

  // Terminal state ignores clear, escalation wins in the same cycle
  assign clear_ok      = clear_after_error_i && !esc_i && !fsm_error_o;
  assign core_if.clear = clear_ok;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_if.cmd <= kmac_cmd_pkg::CmdNone;
    end else begin
      core_if.cmd <= block_swcmd ? kmac_cmd_pkg::CmdNone : sw_cmd_i;
    end
  end

  always_comb begin
    st_d = st_q;
    case (st_q)
      kmac_cmd_pkg::StIdle:       if (start_ok) st_d = kmac_cmd_pkg::StMsgFeed;
      kmac_cmd_pkg::StMsgFeed: begin
        if (sw_cmd_i == kmac_cmd_pkg::CmdProcess) st_d = kmac_cmd_pkg::StProcessing;
      end
      kmac_cmd_pkg::StProcessing: if (core_if.absorbed) st_d = kmac_cmd_pkg::StAbsorbed;
      kmac_cmd_pkg::StAbsorbed: begin
        if (sw_cmd_i == kmac_cmd_pkg::CmdManualRun) begin
          st_d = kmac_cmd_pkg::StSqueezing;
        end else if (sw_cmd_i == kmac_cmd_pkg::CmdDone) begin
          st_d = kmac_cmd_pkg::StIdle;
        end
      end
      kmac_cmd_pkg::StSqueezing:  if (core_if.done) st_d = kmac_cmd_pkg::StAbsorbed;
      default:                    st_d = kmac_cmd_pkg::StTerminalError;
    endcase
    // Blocked command leaves the state untouched
    if (block_swcmd && !fsm_error_o) st_d = st_q;
    if (esc_i) st_d = kmac_cmd_pkg::StTerminalError;
    if (clear_ok) st_d = kmac_cmd_pkg::StIdle;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q <= kmac_cmd_pkg::StIdle;
    end else begin
      st_q <= st_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Error code encoder
  ////////////////////////////////////////////////////////////

  assign err_flags = {err_entropy, err_swsequence, err_modestrength, err_prefix};

  // Priority: sequence, mode, prefix, entropy
  always_comb begin
    error_o = '{valid: 1'b0, code: kmac_cmd_pkg::ErrNone, info: '0};
    if (err_flags != 4'b0000) begin
      error_o.valid = 1'b1;
      // Info layout {4'h0, flags, 5'h0, state, 2'b00, command}
      error_o.info  = {4'h0, err_flags, 5'h00, st_q, 2'b00, sw_cmd_i};
    end
    if (err_swsequence) begin
      error_o.code = kmac_cmd_pkg::ErrSwCmdSequence;
    end else if (err_modestrength) begin
      error_o.code = kmac_cmd_pkg::ErrUnexpectedModeStrength;
    end else if (err_prefix) begin
      error_o.code = kmac_cmd_pkg::ErrIncorrectFunctionName;
    end else if (err_entropy) begin
      error_o.code = kmac_cmd_pkg::ErrSwHashingWithoutEntropyReady;
    end
  end

endmodule

/* hw/kmac_round_ctrl.sv */
// Round counter for absorb and squeeze; a command arriving while busy is ignored
`timescale 1ns/1ps

module kmac_round_ctrl (
  input  logic     clk_i,
  input  logic     rst_ni,
  output logic     busy_o,
  kmac_cmd_if.core core_if
);

  logic [sha3_cfg_pkg::RoundCntW-1:0] cnt_q;

  logic busy_q;
  logic run_absorb_q;
  logic absorbed_q;
  logic done_q;
  logic start_run;

  // Process starts the absorb permutation, ManualRun a squeeze
  assign start_run = core_if.cmd inside {kmac_cmd_pkg::CmdProcess, kmac_cmd_pkg::CmdManualRun};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q        <= '0;
      busy_q       <= 1'b0;
      run_absorb_q <= 1'b0;
      absorbed_q   <= 1'b0;
      done_q       <= 1'b0;
    end else if (core_if.clear) begin
      // Abort whatever is running
      cnt_q      <= '0;
      busy_q     <= 1'b0;
      absorbed_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      absorbed_q <= 1'b0;
      done_q     <= 1'b0;
      if (start_run && !busy_q) begin
        cnt_q        <= sha3_cfg_pkg::RoundCntW'(sha3_cfg_pkg::KeccakRounds);
        busy_q       <= 1'b1;
        run_absorb_q <= (core_if.cmd == kmac_cmd_pkg::CmdProcess);
      end else if (busy_q) begin
        if (cnt_q == sha3_cfg_pkg::RoundCntW'(1)) begin
          // Last round, report the kind of run that just finished
          cnt_q      <= '0;
          busy_q     <= 1'b0;
          absorbed_q <= run_absorb_q;
          done_q     <= !run_absorb_q;
        end else begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end
  end

  assign busy_o           = busy_q;
  assign core_if.absorbed = absorbed_q;
  assign core_if.done     = done_q;

endmodule

/* hw/sha3_cfg_pkg.sv */
// SHA3 mode and strength encodings and the permutation round count assumed by the round controller
package sha3_cfg_pkg;

  // Hash mode selector
  typedef enum logic [1:0] {
    Sha3   = 2'b00,
    Shake  = 2'b10,
    CShake = 2'b11
  } sha3_mode_e;

  // Security strength in bits
  typedef enum logic [2:0] {
    L128 = 3'b000,
    L224 = 3'b001,
    L256 = 3'b010,
    L384 = 3'b011,
    L512 = 3'b100
  } keccak_strength_e;

  // One round per cycle, so this is also the permutation length in cycles
  localparam int KeccakRounds = 24;
  localparam int RoundCntW    = $clog2(KeccakRounds + 1);

endpackage

/* run_sim.sh */
#!/bin/sh
# Run from the project root; exit status is nonzero on any failure
verilator --binary --timing --assert -f all.f --top-module kmac_tb > build.log 2>&1 \
  && ./obj_dir/Vkmac_tb > sim.log 2>&1 \
  || { echo "FAIL: build or simulation stopped, see build.log and sim.log"; exit 1; }
grep -q "Verification failed" sim.log && { echo "FAIL: see sim.log"; exit 1; } || echo "PASS"

/* tests/kmac_asserts.sv */
// Bound into the sequence checker and watching core status through its interface port
`timescale 1ns/1ps

module kmac_asserts (
  input logic                    clk_i,
  input logic                    rst_ni,
  input kmac_cmd_pkg::kmac_cmd_e cmd_i,
  input kmac_cmd_pkg::seq_st_e   st_i,
  input logic                    absorbed_i,
  input logic                    done_i,
  input logic                    fsm_error_i
);

  // End pulses arrive only in the state that waits for them, which also keeps them apart
  a_absorbed_in_processing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    absorbed_i |-> ((st_i == kmac_cmd_pkg::StProcessing) || fsm_error_i))
    else $error("absorbed pulsed while the FSM was not in Processing");

  a_done_in_squeezing: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_i |-> ((st_i == kmac_cmd_pkg::StSqueezing) || fsm_error_i))
    else $error("done pulsed while the FSM was not in Squeezing");

  // Forwarded Start was sampled while the FSM sat in Idle
  a_start_from_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cmd_i == kmac_cmd_pkg::CmdStart) |-> ($past(st_i) == kmac_cmd_pkg::StIdle))
    else $error("Start forwarded from a state other than Idle");

  // Terminal error has no way out
  a_fsm_error_sticky: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_error_i |=> fsm_error_i)
    else $error("fsm_error dropped after being raised");

endmodule

bind kmac_errchk kmac_asserts u_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .cmd_i       (core_if.cmd),
  .st_i        (st_q),
  .absorbed_i  (core_if.absorbed),
  .done_i      (core_if.done),
  .fsm_error_i (fsm_error_o)
);

/* tests/kmac_clk_gen.sv */
// Free-running 40 ns clock; reset is released on a falling edge after 8 rising edges
`timescale 1ns/1ps

module kmac_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // Half period of 20 ns
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Release away from the rising edge so the DUT sees a clean deassert
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tests/kmac_stim.txt */
# cmd: 0 None 1 Start 2 Process 3 ManualRun 4 Done; mode: 0 Sha3 2 Shake 3 CShake; str: 0..4 L128..L512
# cmd mode str kmac pfx_ok unsup ent app esc ack clr wait(1 abs 2 done 3 quiet) valid code info fsm busy
# Legal SHA3-256 hash
1 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
2 0 2 0 1 0 0 0 0 0 0 1  0 0 000000 0 0
3 0 2 0 1 0 0 0 0 0 0 2  0 0 000000 0 0
4 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
# Process in Idle, then a normal hash
2 0 2 0 1 0 0 0 0 0 0 0  1 1 04002e 0 0
0 0 2 0 1 0 0 0 0 1 0 0  0 0 000000 0 0
1 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
2 0 2 0 1 0 0 0 0 0 0 1  0 0 000000 0 0
4 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
# Shake at L512, blocked first, then allowed
1 2 4 0 1 0 0 0 0 0 0 0  1 2 02001d 0 0
2 2 4 0 1 0 0 0 0 0 0 0  1 2 02001d 0 0
0 2 4 0 1 0 0 0 0 1 0 0  0 0 000000 0 0
1 2 4 0 1 1 0 0 0 0 0 0  1 2 02001d 0 0
2 2 4 0 1 1 0 0 0 0 0 1  1 2 02001d 0 0
3 2 4 0 1 1 0 0 0 0 0 2  1 2 02001d 0 0
4 2 4 0 1 1 0 0 0 1 0 0  0 0 000000 0 0
# KMAC with wrong prefix, entropy seen before Start
0 0 2 1 0 0 1 0 0 0 0 0  0 0 000000 0 0
1 0 2 1 0 0 0 0 0 0 0 0  1 3 01001d 0 0
2 0 2 1 0 0 0 0 0 0 0 1  1 3 01001d 0 0
4 0 2 1 0 0 0 0 0 1 0 0  0 0 000000 0 0
# KMAC without entropy, Start blocked so Process never runs
1 0 2 1 1 0 0 0 0 0 0 0  1 4 08001d 0 0
2 0 2 1 1 0 0 0 0 0 0 0  1 4 08001d 0 0
0 0 2 1 1 0 0 0 0 1 0 0  0 0 000000 0 0
# Clear-after-error during Processing, then a fresh hash
1 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
2 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 1
0 0 2 0 1 0 0 0 0 0 1 0  0 0 000000 0 0
1 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
2 0 2 0 1 0 0 0 0 0 0 1  0 0 000000 0 0
4 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 0 0
# Escalation, no recovery through clear
0 0 2 0 1 0 0 0 1 0 0 0  0 0 000000 1 0
1 0 2 0 1 0 0 0 0 0 0 0  0 0 000000 1 0
2 0 2 0 1 0 0 0 0 0 0 3  0 0 000000 1 0
0 0 2 0 1 0 0 0 0 0 1 0  0 0 000000 1 0
2 0 2 0 1 0 0 0 0 0 0 3  0 0 000000 1 0

/* tests/kmac_tb.sv */
// Reads tests/kmac_stim.txt from the project root; at most 64 steps, stops at the first mismatch
`timescale 1ns/1ps

module kmac_tb;

  logic                           clk;
  logic                           rst_n;
  sha3_cfg_pkg::sha3_mode_e       cfg_mode_i;
  sha3_cfg_pkg::keccak_strength_e cfg_strength_i;
  logic                           kmac_en_i;
  logic [47:0]                    cfg_prefix_i;
  logic                           cfg_en_unsupported_i;
  logic                           entropy_ready_i;
  logic                           app_active_i;
  logic                           esc_i;
  logic                           err_processed_i;
  logic                           clear_after_error_i;
  kmac_cmd_pkg::kmac_cmd_e        sw_cmd_i;
  logic                           absorbed_o;
  logic                           done_o;
  logic                           busy_o;
  logic                           err_valid_o;
  kmac_cmd_pkg::err_code_e        err_code_o;
  logic [23:0]                    err_info_o;
  logic                           fsm_error_o;

  // One row per step, 17 columns as laid out in the stim file
  int stim [64][17];
  int num_steps;
  int cur_step;
  int cycles;
  int cycle_limit;

  kmac_clk_gen u_clk_gen (.clk_o(clk), .rst_no(rst_n));

  kmac_ctrl_top uut (.clk_i(clk), .rst_ni(rst_n), .*);

  //////////////////////////////////////////////////////////////
  // Failure reporting and compare helpers
  //////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "Run stopped at the first failure");
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      abort_run($sformatf("Error at %0t: step %0d %s is %b, expected %b",
                          $time, cur_step, name, act, exp));
    end
  endtask

  task automatic check_code(input kmac_cmd_pkg::err_code_e act,
                            input kmac_cmd_pkg::err_code_e exp);
    if (act !== exp) begin
      abort_run($sformatf("Error at %0t: step %0d err_code_o is %s, expected %s",
                          $time, cur_step, act.name(), exp.name()));
    end
  endtask

  task automatic check_info(input logic [23:0] act, input logic [23:0] exp);
    if (act !== exp) begin
      abort_run($sformatf("Error at %0t: step %0d err_info_o is %06h, expected %06h",
                          $time, cur_step, act, exp));
    end
  endtask

  // File column indices to command and error code names
  function automatic kmac_cmd_pkg::kmac_cmd_e cmd_from_index(input int idx);
    case (idx)
      1:       return kmac_cmd_pkg::CmdStart;
      2:       return kmac_cmd_pkg::CmdProcess;
      3:       return kmac_cmd_pkg::CmdManualRun;
      4:       return kmac_cmd_pkg::CmdDone;
      default: return kmac_cmd_pkg::CmdNone;
    endcase
  endfunction

  function automatic kmac_cmd_pkg::err_code_e code_from_index(input int idx);
    case (idx)
      1:       return kmac_cmd_pkg::ErrSwCmdSequence;
      2:       return kmac_cmd_pkg::ErrUnexpectedModeStrength;
      3:       return kmac_cmd_pkg::ErrIncorrectFunctionName;
      4:       return kmac_cmd_pkg::ErrSwHashingWithoutEntropyReady;
      default: return kmac_cmd_pkg::ErrNone;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////
  // Waits on core pulses
  //////////////////////////////////////////////////////////////

  // Kind 1 waits for absorbed_o, kind 2 for done_o
  task automatic wait_pulse(input int kind);
    int n;
    logic seen;
    n = 0;
    seen = 1'b0;
    while (!seen && n < sha3_cfg_pkg::KeccakRounds + 4) begin
      seen = (kind == 1) ? absorbed_o : done_o;
      if (!seen) begin
        @(negedge clk);
        n++;
      end
    end
    if (!seen) begin
      abort_run($sformatf("Step %0d: %s never pulsed", cur_step,
                          (kind == 1) ? "absorbed_o" : "done_o"));
    end
  endtask

  // A full permutation length with neither pulse
  task automatic expect_quiet();
    repeat (sha3_cfg_pkg::KeccakRounds + 4) begin
      if (absorbed_o || done_o) begin
        abort_run($sformatf("Step %0d: the core finished a run it should not have started",
                            cur_step));
      end
      @(negedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////
  // Step driver
  //////////////////////////////////////////////////////////////

  task automatic run_step(input int s);
    cur_step = s;
    @(negedge clk);
    sw_cmd_i             = cmd_from_index(stim[s][0]);
    cfg_mode_i           = sha3_cfg_pkg::sha3_mode_e'(2'(stim[s][1]));
    cfg_strength_i       = sha3_cfg_pkg::keccak_strength_e'(3'(stim[s][2]));
    kmac_en_i            = (stim[s][3] != 0);
    // Inverted name is a prefix that can never match
    cfg_prefix_i         = (stim[s][4] != 0) ? kmac_cmd_pkg::EncodedStringKMAC
                                             : ~kmac_cmd_pkg::EncodedStringKMAC;
    cfg_en_unsupported_i = (stim[s][5] != 0);
    entropy_ready_i      = (stim[s][6] != 0);
    app_active_i         = (stim[s][7] != 0);
    esc_i                = (stim[s][8] != 0);
    err_processed_i      = (stim[s][9] != 0);
    clear_after_error_i  = (stim[s][10] != 0);
    @(negedge clk);
    // Strobes last a single cycle, configuration stays
    sw_cmd_i            = kmac_cmd_pkg::CmdNone;
    entropy_ready_i     = 1'b0;
    esc_i               = 1'b0;
    err_processed_i     = 1'b0;
    clear_after_error_i = 1'b0;
    @(negedge clk);
    if (stim[s][11] == 1 || stim[s][11] == 2) begin
      wait_pulse(stim[s][11]);
    end else if (stim[s][11] == 3) begin
      expect_quiet();
    end
    check_bit("err_valid_o", err_valid_o, stim[s][12] != 0);
    check_code(err_code_o, code_from_index(stim[s][13]));
    check_info(err_info_o, 24'(stim[s][14]));
    check_bit("fsm_error_o", fsm_error_o, stim[s][15] != 0);
    check_bit("busy_o", busy_o, stim[s][16] != 0);
  endtask

  // Cycle budget, armed once the step count is known
  always @(posedge clk) begin
    if (rst_n) begin
      cycles = cycles + 1;
      if (cycle_limit != 0 && cycles >= cycle_limit) begin
        abort_run($sformatf("Timeout: no result after %0d cycles", cycles));
      end
    end
  end

  initial begin
    int fd;
    int n;
    int f[17];
    string line;
    sw_cmd_i             = kmac_cmd_pkg::CmdNone;
    cfg_mode_i           = sha3_cfg_pkg::Sha3;
    cfg_strength_i       = sha3_cfg_pkg::L256;
    kmac_en_i            = 1'b0;
    cfg_prefix_i         = kmac_cmd_pkg::EncodedStringKMAC;
    cfg_en_unsupported_i = 1'b0;
    entropy_ready_i      = 1'b0;
    app_active_i         = 1'b0;
    esc_i                = 1'b0;
    err_processed_i      = 1'b0;
    clear_after_error_i  = 1'b0;
    num_steps   = 0;
    cycles      = 0;
    cycle_limit = 0;
    fd = $fopen("tests/kmac_stim.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open tests/kmac_stim.txt");
    end
    // Comment lines start with # and never match the first number
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %h %d %d",
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                  f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
      if (n == 17 && num_steps < 64) begin
        for (int i = 0; i < 17; i++) begin
          stim[num_steps][i] = f[i];
        end
        num_steps++;
      end else if (n > 0) begin
        abort_run("Malformed or excess line in the stimulus file");
      end
    end
    $fclose(fd);
    cycle_limit = num_steps * (sha3_cfg_pkg::KeccakRounds + 8);
    @(posedge rst_n);
    for (int s = 0; s < num_steps; s++) begin
      run_step(s);
    end
    $display("Verification passed");
    $finish;
  end

endmodule
